/* Bender.yml */
package:
  name: az_meas

sources:
  # packages first, then the datapath and control modules.
  - files:
      - design/az_ctrl_pkg.sv
      - design/az_result_pkg.sv
      - design/az_phase_timer.sv
      - design/az_sample_counter.sv
      - design/az_sequencer.sv
      - design/az_result_link.sv
      - design/az_meas_top.sv
  - target: test
    files:
      - dv/az_clock_gen.sv
      - dv/az_meas_tb.sv

/* design/az_ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// switch levels, az mux codes and phase encoding for the auto-zero sequencer.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package az_ctrl_pkg;

  // precharge switch levels.
  // boot holds the signal node on the precharge amplifier.
  localparam logic SW_PC_BOOT   = 1'b0;
  // signal connects the input to the converter.
  localparam logic SW_PC_SIGNAL = 1'b1;

  // az mux code that routes the precharge output to the converter.
  localparam logic [3:0] MUX_AZ_PC_OUT = 4'b1000;

  // sequencer phases, in the order one measurement walks through them.
  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    BOOT_PROTECT = 3'd1,
    SETTLE       = 3'd2,
    SIG_SAMPLE   = 3'd3,
    REPROTECT    = 3'd4,
    ZERO_SAMPLE  = 3'd5,
    HANDOFF      = 3'd6
  } az_phase_e;

endpackage

`default_nettype wire

/* design/az_meas_top.sv */
////////////////////////////////////////////////////////////////////////////
// auto-zero measurement top. sequencer, phase timer, counter and link.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module az_meas_top #(
  parameter int unsigned SAMPLE_CYCLES    = 400000,
  parameter int unsigned PRECHARGE_CYCLES = 20000,
  parameter int unsigned CREDITS          = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      run,
  input  logic [3:0]                az_mux_val,
  input  logic                      comp,
  output logic                      sw_pc_ctl,
  output logic [3:0]                azmux,
  output logic [7:0]                monitor,
  output az_result_pkg::az_result_t result,
  output logic                      result_valid,
  input  logic                      credit_return
);

  // sequencer to timer.
  logic        timer_load;
  logic [31:0] timer_value;
  logic        timer_done;
  // sequencer to counter.
  logic        sig_window;
  logic        zero_window;
  logic        close;
  // sequencer and link.
  logic        send;
  logic        can_send;
  // counter to link.
  logic                      pair_ready;
  az_result_pkg::az_result_t pair;

  az_sequencer #(
    .SAMPLE_CYCLES    (SAMPLE_CYCLES),
    .PRECHARGE_CYCLES (PRECHARGE_CYCLES)
  ) u_sequencer (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .az_mux_val  (az_mux_val),
    .timer_done  (timer_done),
    .can_send    (can_send),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .sw_pc_ctl   (sw_pc_ctl),
    .azmux       (azmux),
    .sig_window  (sig_window),
    .zero_window (zero_window),
    .close       (close),
    .send        (send),
    .monitor     (monitor)
  );

  az_phase_timer u_timer (
    .clk        (clk),
    .reset      (reset),
    .load       (timer_load),
    .load_value (timer_value),
    .done       (timer_done)
  );

  // azmux still holds the lo input on the close cycle.
  az_sample_counter u_counter (
    .clk         (clk),
    .reset       (reset),
    .comp        (comp),
    .sig_window  (sig_window),
    .zero_window (zero_window),
    .close       (close),
    .mux_sel     (azmux),
    .result      (pair),
    .pair_ready  (pair_ready)
  );

  az_result_link #(
    .CREDITS (CREDITS)
  ) u_link (
    .clk           (clk),
    .reset         (reset),
    .send          (send),
    .pair_ready    (pair_ready),
    .pair          (pair),
    .credit_return (credit_return),
    .can_send      (can_send),
    .result        (result),
    .result_valid  (result_valid)
  );

endmodule

`default_nettype wire

/* design/az_phase_timer.sv */
////////////////////////////////////////////////////////////////////////////
// phase timer. the sequencer loads a length, done marks the last cycle.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module az_phase_timer (
  input  logic        clk,
  input  logic        reset,
  input  logic        load,
  input  logic [31:0] load_value,
  output logic        done
);

  // cycles left in the current phase.
  logic [31:0] count;

  // load wins over the decrement.
  // a new phase is loaded on the same edge the old one ends.
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count <= '0;
    end
    else if (load)
    begin
      count <= load_value;
    end
    else if (count != '0)
    begin
      // parks at zero once a phase has run out.
      count <= count - 32'd1;
    end
  end

  // high in the final cycle of the phase, so the sequencer leaves
  // on the next edge and the phase lasts exactly load_value cycles.
  assign done = (count == 32'd1);

endmodule

`default_nettype wire

/* design/az_result_link.sv */
////////////////////////////////////////////////////////////////////////////
// credit-based sender of result packets. one slot is reserved per pair.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module az_result_link #(
  parameter int unsigned CREDITS = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      send,
  input  logic                      pair_ready,
  input  az_result_pkg::az_result_t pair,
  input  logic                      credit_return,
  output logic                      can_send,
  output az_result_pkg::az_result_t result,
  output logic                      result_valid
);

  localparam int CNT_W = $clog2(CREDITS + 1);

  // credits held, i.e. free entries in the consumer buffer.
  logic [CNT_W-1:0] credit_cnt;
  // slot reserved for the pair now being measured.
  logic             pending;
  logic             spend;

  // a packet leaves only with a credit in hand.
  assign spend    = pair_ready && (credit_cnt != '0);
  assign can_send = (credit_cnt != '0) && !pending;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      credit_cnt   <= CNT_W'(CREDITS);
      // the boot pass measures a pair without going through handoff.
      pending      <= 1'b1;
      result_valid <= 1'b0;
    end
    else
    begin
      result_valid <= spend;
      // spend and return on one edge cancel out.
      if (spend && !credit_return)
        credit_cnt <= credit_cnt - 1'b1;
      else if (credit_return && !spend)
        credit_cnt <= credit_cnt + 1'b1;
      if (send)
        pending <= 1'b1;
      else if (spend)
        pending <= 1'b0;
    end
  end

  // held steady until the next packet.
  always_ff @(posedge clk)
  begin
    if (spend)
      result <= pair;
  end

endmodule

`default_nettype wire

/* design/az_result_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// result packet carried from the sample counter to the consumer.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package az_result_pkg;

  // width of each window count.
  // wide enough for a full 1 nplc window at the real clock.
  localparam int COUNT_W = 24;

  // one signal/zero pair.
  // diff is one bit wider so the sign always fits.
  typedef struct packed {
    // ones counted while the signal was connected.
    logic [COUNT_W-1:0]      sig_count;
    // ones counted on the lo input.
    logic [COUNT_W-1:0]      zero_count;
    // sig_count minus zero_count.
    logic signed [COUNT_W:0] diff;
    // lo mux input used for the zero sample.
    logic [3:0]              mux_sel;
  } az_result_t;

endpackage

`default_nettype wire

/* design/az_sample_counter.sv */
////////////////////////////////////////////////////////////////////////////
// counts comparator ones per window and latches the pair on close.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module az_sample_counter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      comp,
  input  logic                      sig_window,
  input  logic                      zero_window,
  input  logic                      close,
  input  logic [3:0]                mux_sel,
  output az_result_pkg::az_result_t result,
  output logic                      pair_ready
);

  // running counts for the open measurement.
  logic [az_result_pkg::COUNT_W-1:0] sig_acc;
  logic [az_result_pkg::COUNT_W-1:0] zero_acc;
  // zero-extend both counts before subtracting.
  logic signed [az_result_pkg::COUNT_W:0] diff_next;

  assign diff_next = $signed({1'b0, sig_acc}) - $signed({1'b0, zero_acc});

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sig_acc    <= '0;
      zero_acc   <= '0;
      pair_ready <= 1'b0;
    end
    else
    begin
      // the pair is valid the cycle after close.
      pair_ready <= close;
      if (close)
      begin
        // start clean for the next measurement.
        sig_acc  <= '0;
        zero_acc <= '0;
      end
      else
      begin
        if (sig_window && comp)
          sig_acc <= sig_acc + 1'b1;
        if (zero_window && comp)
          zero_acc <= zero_acc + 1'b1;
      end
    end
  end

  // result register, written only when a pair closes.
  always_ff @(posedge clk)
  begin
    if (close)
    begin
      result.sig_count  <= sig_acc;
      result.zero_count <= zero_acc;
      result.diff       <= diff_next;
      result.mux_sel    <= mux_sel;
    end
  end

endmodule

`default_nettype wire

/* design/az_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// auto-zero control FSM. steps the precharge switch and az mux through
// boot, settle, signal, re-protect and zero, then hands the pair off.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module az_sequencer #(
  parameter int unsigned SAMPLE_CYCLES    = 400000,
  parameter int unsigned PRECHARGE_CYCLES = 20000
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  input  logic [3:0]  az_mux_val,
  input  logic        timer_done,
  input  logic        can_send,
  output logic        timer_load,
  output logic [31:0] timer_value,
  output logic        sw_pc_ctl,
  output logic [3:0]  azmux,
  output logic        sig_window,
  output logic        zero_window,
  output logic        close,
  output logic        send,
  output logic [7:0]  monitor
);

  az_ctrl_pkg::az_phase_e state;
  az_ctrl_pkg::az_phase_e next_state;
  // lo input captured in settle, used for this cycle's zero sample.
  logic [3:0] lo_sel;

  ////////////////////////////////////////////////////////////////////////////
  // next state.

  always_comb
  begin
    next_state = state;
    case (state)
      az_ctrl_pkg::IDLE:
        next_state = az_ctrl_pkg::BOOT_PROTECT;
      az_ctrl_pkg::BOOT_PROTECT:
        if (timer_done)
          next_state = az_ctrl_pkg::SETTLE;
      az_ctrl_pkg::SETTLE:
        if (timer_done)
          next_state = az_ctrl_pkg::SIG_SAMPLE;
      az_ctrl_pkg::SIG_SAMPLE:
        if (timer_done)
          next_state = az_ctrl_pkg::REPROTECT;
      az_ctrl_pkg::REPROTECT:
        if (timer_done)
          next_state = az_ctrl_pkg::ZERO_SAMPLE;
      az_ctrl_pkg::ZERO_SAMPLE:
        if (timer_done)
          next_state = az_ctrl_pkg::HANDOFF;
      az_ctrl_pkg::HANDOFF:
        // a credit must be reserved before the next pair is measured.
        if (can_send && run)
          next_state = az_ctrl_pkg::SETTLE;
      default:
        next_state = az_ctrl_pkg::IDLE;
    endcase
  end

  // every phase except handoff is timed; idle is never re-entered.
  assign timer_load  = (next_state != state) && (next_state != az_ctrl_pkg::HANDOFF);
  assign timer_value = (next_state == az_ctrl_pkg::SIG_SAMPLE ||
                        next_state == az_ctrl_pkg::ZERO_SAMPLE) ?
                       32'(SAMPLE_CYCLES) : 32'(PRECHARGE_CYCLES);

  // reserve the link slot on the way out of handoff.
  assign send = (state == az_ctrl_pkg::HANDOFF) && can_send && run;

  ////////////////////////////////////////////////////////////////////////////
  // state and switch registers, updated on the edge a phase is entered.

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state       <= az_ctrl_pkg::IDLE;
      sw_pc_ctl   <= az_ctrl_pkg::SW_PC_BOOT;
      azmux       <= az_ctrl_pkg::MUX_AZ_PC_OUT;
      lo_sel      <= '0;
      sig_window  <= 1'b0;
      zero_window <= 1'b0;
      close       <= 1'b0;
      monitor     <= '0;
    end
    else
    begin
      state <= next_state;
      // one pulse in the first handoff cycle.
      close <= (state == az_ctrl_pkg::ZERO_SAMPLE) && (next_state == az_ctrl_pkg::HANDOFF);
      if (next_state != state)
      begin
        case (next_state)
          az_ctrl_pkg::BOOT_PROTECT:
          begin
            // protect the signal before touching the az mux.
            sw_pc_ctl <= az_ctrl_pkg::SW_PC_BOOT;
            monitor   <= '0;
          end
          az_ctrl_pkg::SETTLE:
          begin
            // pc is at boot here, safe to move the az mux.
            azmux      <= az_ctrl_pkg::MUX_AZ_PC_OUT;
            lo_sel     <= az_mux_val;
            monitor[0] <= 1'b1;
            monitor[3] <= 1'b0;
          end
          az_ctrl_pkg::SIG_SAMPLE:
          begin
            sw_pc_ctl  <= az_ctrl_pkg::SW_PC_SIGNAL;
            sig_window <= 1'b1;
            monitor[1] <= 1'b1;
          end
          az_ctrl_pkg::REPROTECT:
          begin
            sw_pc_ctl  <= az_ctrl_pkg::SW_PC_BOOT;
            sig_window <= 1'b0;
            monitor[1] <= 1'b0;
          end
          az_ctrl_pkg::ZERO_SAMPLE:
          begin
            // lo input is sampled with the signal still protected.
            azmux       <= lo_sel;
            zero_window <= 1'b1;
            monitor[0]  <= 1'b0;
            monitor[2]  <= 1'b1;
          end
          az_ctrl_pkg::HANDOFF:
          begin
            zero_window <= 1'b0;
            monitor[2]  <= 1'b0;
            monitor[3]  <= 1'b1;
          end
          default:
          begin
            monitor <= '0;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* dv/az_clock_gen.sv */
////////////////////////////////////////////////////////////////////////////
// testbench clock and reset. reset is released just after a rising edge.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module az_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    // same skew as the other stimulus.
    #2;
    reset = 1'b0;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

/* dv/az_meas_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the auto-zero top. random comparator, credit consumer,
// reference counts and checks on the monitor, switches and result link.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module az_meas_tb;

  localparam int unsigned SAMPLE_CYCLES    = 37;
  localparam int unsigned PRECHARGE_CYCLES = 5;
  localparam int unsigned CREDITS          = 2;
  localparam int PERIOD_NS        = 40;
  localparam int MAX_CREDIT_DELAY = 60;
  localparam int HOLD_CYCLES      = 150;
  localparam int RUNLOW_CYCLES    = 120;
  localparam int RESULTS_WANTED   = 10;
  // boot, settle, re-protect, both windows and the shortest handoff.
  localparam int CYCLE_LEN = 3 * PRECHARGE_CYCLES + 2 * SAMPLE_CYCLES + 3;
  localparam int WATCHDOG_CYCLES = 8 + 12 * (CYCLE_LEN + MAX_CREDIT_DELAY)
                                   + HOLD_CYCLES + RUNLOW_CYCLES;

  logic                      clk;
  logic                      reset;
  logic                      run;
  logic [3:0]                az_mux_val;
  logic                      comp;
  logic                      credit_return;
  logic                      sw_pc_ctl;
  logic [3:0]                azmux;
  logic [7:0]                monitor;
  az_result_pkg::az_result_t result;
  logic                      result_valid;

  integer seed;
  int     value_errs;
  int     flow_errs;
  int     results_seen;
  // packets sent and not yet returned as credits.
  int     outstanding;
  int     owed;
  int     wait_left;
  logic   hold_credits;
  logic   saw_run_hold;

  // checker state, one sample behind the DUT.
  logic [7:0] prev_mon;
  logic [3:0] prev_azmux;
  logic       prev_sw;
  logic [3:0] prev_mux_in;
  logic [3:0] cap_lo;
  int         sig_len;
  int         zero_len;
  int         ref_sig;
  int         ref_zero;
  int         due_cnt;
  logic       no_credit;
  logic       must_hold;
  az_result_pkg::az_result_t exp_q[$];

  az_clock_gen #(
    .PERIOD_NS    (PERIOD_NS),
    .RESET_CYCLES (8)
  ) u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  az_meas_top #(
    .SAMPLE_CYCLES    (SAMPLE_CYCLES),
    .PRECHARGE_CYCLES (PRECHARGE_CYCLES),
    .CREDITS          (CREDITS)
  ) UUT (
    .clk           (clk),
    .reset         (reset),
    .run           (run),
    .az_mux_val    (az_mux_val),
    .comp          (comp),
    .sw_pc_ctl     (sw_pc_ctl),
    .azmux         (azmux),
    .monitor       (monitor),
    .result        (result),
    .result_valid  (result_valid),
    .credit_return (credit_return)
  );

  task automatic report_mismatch(input string name, input int got, input int expected);
  begin
    value_errs++;
    $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
  end
  endtask

  task automatic report_problem(input string what);
  begin
    flow_errs++;
    $display("error at %0t ns: %s", $time, what);
  end
  endtask

  task automatic check_reset_values();
  begin
    assert (sw_pc_ctl == az_ctrl_pkg::SW_PC_BOOT)
      else report_mismatch("sw_pc_ctl", sw_pc_ctl, az_ctrl_pkg::SW_PC_BOOT);
    assert (azmux == az_ctrl_pkg::MUX_AZ_PC_OUT)
      else report_mismatch("azmux", azmux, az_ctrl_pkg::MUX_AZ_PC_OUT);
    assert (monitor == 8'h00) else report_mismatch("monitor", monitor, 0);
    assert (result_valid == 1'b0) else report_mismatch("result_valid", result_valid, 0);
  end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and consumer.

  // comparator bit every cycle, lo input now and then.
  always @(posedge clk)
  begin
    #2;
    comp = $random(seed);
    if (($random(seed) & 15) == 0)
      az_mux_val = $random(seed);
  end

  // consumer buffer, hands credits back one at a time.
  always @(posedge clk)
  begin : consume_packets
    logic hold_now;
    hold_now = hold_credits;
    if (result_valid)
    begin
      if (owed == 0)
        wait_left = {$random(seed)} % (MAX_CREDIT_DELAY + 1);
      owed = owed + 1;
    end
    #2;
    credit_return = 1'b0;
    if (owed > 0 && !hold_now)
    begin
      if (wait_left == 0)
      begin
        credit_return = 1'b1;
        owed          = owed - 1;
        wait_left     = {$random(seed)} % (MAX_CREDIT_DELAY + 1);
      end
      else
        wait_left = wait_left - 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks, sampled on the rising edge.

  always @(posedge clk)
  begin : check_outputs
    az_result_pkg::az_result_t expd;
    logic want_valid;
    if (reset)
    begin
      prev_mon    = '0;
      prev_azmux  = az_ctrl_pkg::MUX_AZ_PC_OUT;
      prev_sw     = az_ctrl_pkg::SW_PC_BOOT;
      prev_mux_in = az_mux_val;
      cap_lo      = '0;
      sig_len     = 0;
      zero_len    = 0;
      ref_sig     = 0;
      ref_zero    = 0;
      due_cnt     = 0;
      outstanding = 0;
      no_credit   = 1'b0;
      must_hold   = 1'b0;
    end
    else
    begin
      // reference counts, ones seen while a window is open.
      if (monitor[1] && comp)
        ref_sig++;
      if (monitor[2] && comp)
        ref_zero++;
      if (monitor[1])
        sig_len++;
      if (monitor[2])
        zero_len++;
      if (prev_mon[1] && !monitor[1])
      begin
        assert (sig_len == SAMPLE_CYCLES)
          else report_mismatch("signal window length", sig_len, SAMPLE_CYCLES);
        sig_len = 0;
      end
      if (prev_mon[2] && !monitor[2])
      begin
        assert (zero_len == SAMPLE_CYCLES)
          else report_mismatch("zero window length", zero_len, SAMPLE_CYCLES);
        zero_len = 0;
      end
      // settle was entered on the previous edge.
      if (!prev_mon[0] && monitor[0])
        cap_lo = prev_mux_in;

      // the az mux may only move with the signal protected.
      if (azmux != prev_azmux)
        assert (prev_sw == az_ctrl_pkg::SW_PC_BOOT && sw_pc_ctl == az_ctrl_pkg::SW_PC_BOOT)
          else report_problem("azmux changed while the precharge switch was at signal");
      if (monitor[1])
      begin
        assert (azmux == az_ctrl_pkg::MUX_AZ_PC_OUT)
          else report_mismatch("azmux", azmux, az_ctrl_pkg::MUX_AZ_PC_OUT);
        assert (sw_pc_ctl == az_ctrl_pkg::SW_PC_SIGNAL)
          else report_mismatch("sw_pc_ctl", sw_pc_ctl, az_ctrl_pkg::SW_PC_SIGNAL);
      end
      // zero window and handoff keep the captured lo input.
      if (monitor[2] || monitor[3])
      begin
        assert (azmux == cap_lo) else report_mismatch("azmux", azmux, cap_lo);
        assert (sw_pc_ctl == az_ctrl_pkg::SW_PC_BOOT)
          else report_mismatch("sw_pc_ctl", sw_pc_ctl, az_ctrl_pkg::SW_PC_BOOT);
      end

      // flags from the last edge.
      if (no_credit)
        assert (!result_valid) else report_problem("result_valid sent without a credit");
      if (must_hold)
        assert (monitor[3]) else report_problem("handoff left with run low or no credit");
      if (prev_mon[3] && !monitor[3])
        assert (monitor == 8'h01) else report_mismatch("monitor after handoff", monitor, 1);

      // the packet is due two edges after the zero window closes.
      want_valid = (due_cnt == 1);
      if (due_cnt != 0)
        due_cnt--;
      assert (result_valid == want_valid)
        else report_mismatch("result_valid", result_valid, want_valid);
      if (result_valid)
      begin
        results_seen++;
        if (exp_q.size() == 0)
          report_problem("result_valid without a finished measurement");
        else
        begin
          expd = exp_q.pop_front();
          assert (result.sig_count == expd.sig_count)
            else report_mismatch("result.sig_count", result.sig_count, expd.sig_count);
          assert (result.zero_count == expd.zero_count)
            else report_mismatch("result.zero_count", result.zero_count, expd.zero_count);
          assert (result.diff == expd.diff)
            else report_mismatch("result.diff", int'($signed(result.diff)),
                                 int'($signed(expd.diff)));
          assert (result.mux_sel == expd.mux_sel)
            else report_mismatch("result.mux_sel", result.mux_sel, expd.mux_sel);
        end
      end
      if (prev_mon[2] && !monitor[2])
      begin
        expd.sig_count  = ref_sig;
        expd.zero_count = ref_zero;
        expd.diff       = ref_sig - ref_zero;
        expd.mux_sel    = cap_lo;
        exp_q.push_back(expd);
        due_cnt  = 2;
        ref_sig  = 0;
        ref_zero = 0;
      end

      // credits the link holds before this edge are CREDITS minus this sum.
      outstanding = outstanding + result_valid;
      assert (outstanding <= CREDITS) else report_problem("more packets outstanding than credits");
      no_credit = (outstanding == CREDITS);
      must_hold = monitor[3] && (no_credit || !run);
      if (monitor[3] && !run)
        saw_run_hold = 1'b1;
      outstanding = outstanding - credit_return;

      prev_mon    = monitor;
      prev_azmux  = azmux;
      prev_sw     = sw_pc_ctl;
      prev_mux_in = az_mux_val;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence and watchdog.

  initial
  begin
    seed          = 32'ha1f0;
    run           = 1'b1;
    comp          = 1'b0;
    az_mux_val    = 4'h3;
    credit_return = 1'b0;
    hold_credits  = 1'b0;
    value_errs    = 0;
    flow_errs     = 0;
    results_seen  = 0;
    owed          = 0;
    wait_left     = 0;
    saw_run_hold  = 1'b0;
    @(negedge reset);
    check_reset_values();
    wait (results_seen >= 3);
    // withhold credits until the sequencer starves in handoff.
    @(posedge clk);
    #2;
    hold_credits = 1'b1;
    wait (no_credit && monitor[3]);
    repeat (HOLD_CYCLES) @(posedge clk);
    #2;
    hold_credits = 1'b0;
    // run goes low early in a cycle, so handoff is reached while it is low.
    wait (!monitor[3]);
    @(posedge clk);
    #2;
    run = 1'b0;
    repeat (RUNLOW_CYCLES) @(posedge clk);
    #2;
    run = 1'b1;
    wait (results_seen >= RESULTS_WANTED);
    repeat (4) @(posedge clk);
    if (!saw_run_hold)
      report_problem("handoff was never reached with run low");
    $display("errors: %0d value, %0d flow", value_errs, flow_errs);
    if (value_errs == 0 && flow_errs == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * PERIOD_NS);
    $display("error: timeout after %0d cycles, %0d of %0d results received",
             WATCHDOG_CYCLES, results_seen, RESULTS_WANTED);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
design/az_ctrl_pkg.sv
design/az_result_pkg.sv
design/az_phase_timer.sv
design/az_sample_counter.sv
design/az_sequencer.sv
design/az_result_link.sv
design/az_meas_top.sv
dv/az_clock_gen.sv
dv/az_meas_tb.sv
